//--- project.f
+incdir+include
design/robEntryPkg.sv
design/robCtrlPkg.sv
design/robControl.sv
design/robEntryStore.sv
design/robRetireSelect.sv
design/robTop.sv
tb/robTb.sv

//--- Bender.yml
package:
  name: rob

export_include_dirs:
  - include

sources:
  # packages first, then the modules that import them
  - files:
      - design/robEntryPkg.sv
      - design/robCtrlPkg.sv
      - design/robControl.sv
      - design/robEntryStore.sv
      - design/robRetireSelect.sv
      - design/robTop.sv

  - target: test
    files:
      - tb/robTb.sv

//--- tb/robTb.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module robTb;
    import robEntryPkg::*;

    localparam int NumTests = 6;

    logic Clk, arstN, stall, flush, extInterrupt;
    logic dispatchValid0, dispatchValid1, dispatchRdValid0, dispatchRdValid1;
    pcT dispatchPc0, dispatchPc1, memFaultAddr, pcReadData, trapPc, trapAddr;
    microOpE dispatchOp0, dispatchOp1;
    archRegT dispatchArchRd0, dispatchArchRd1, commitArchRd0, commitArchRd1;
    physRegT dispatchPhysRd0, dispatchPhysRd1, commitPhysRd0, commitPhysRd1;
    robIdxT allocIdx0, allocIdx1, aluDoneIdx0, aluDoneIdx1, memDoneIdx, pcReadIdx;
    logic robFull, aluDone0, aluDone1, memDone, memTrap;
    logic commitMap0, commitMap1, memRetire, memRetireStore, trapValid;
    trapCodeT memTrapCode, trapCode;
    bufIdxT memBufIdx, memRetireBufIdx;

    // reference model of the buffer contents with the oldest entry first
    robEntryT model[$];
    robIdxT   headPtr;
    logic     trapHold;
    int       errors, passCount, failCount, commitsSeen, memSeen, trapsSeen, seed;

    robTop dut (.*);

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    initial begin
        #(NumTests * 200 * 40);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic compareValue(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic isMem(microOpE op);
        return (op == opLoad) || (op == opStore);
    endfunction

    function automatic robEntryT modelEntry(pcT pc, microOpE op, logic rdValid,
                                            archRegT archRd, physRegT physRd);
        robEntryT ent;
        ent         = '0;
        ent.valid   = 1'b1;
        ent.op      = op;
        ent.rdValid = rdValid;
        ent.archRd  = archRd;
        ent.physRd  = physRd;
        ent.pc      = pc;
        return ent;
    endfunction

    task automatic markDone(input robIdxT idx, input logic fromMem);
        robIdxT   pos;
        robEntryT ent;
        pos = idx - headPtr;
        if (pos < model.size()) begin
            ent      = model[pos];
            ent.done = 1'b1;
            if (fromMem) begin
                ent.trap      = memTrap;
                ent.trapCode  = memTrapCode;
                ent.faultAddr = memFaultAddr;
                ent.bufIdx    = memBufIdx;
            end
            model[pos] = ent;
        end
    endtask

    task automatic driveSlot(input int slot, input microOpE op, input logic rdValid);
        pcT pc;
        pc = $urandom() & 32'hffff_fffc;
        if (slot == 0) begin
            dispatchValid0   = 1'b1;
            dispatchPc0      = pc;
            dispatchOp0      = op;
            dispatchRdValid0 = rdValid;
            dispatchArchRd0  = archRegT'($urandom());
            dispatchPhysRd0  = physRegT'($urandom());
        end else begin
            dispatchValid1   = 1'b1;
            dispatchPc1      = pc;
            dispatchOp1      = op;
            dispatchRdValid1 = rdValid;
            dispatchArchRd1  = archRegT'($urandom());
            dispatchPhysRd1  = physRegT'($urandom());
        end
    endtask

    // predict and check mid-cycle then advance the model at the edge
    task automatic runCycle();
        robEntryT e0, e1, memE, ent;
        logic v0, v1, en, intr, ready0, fault, sys, trap, ret0, ret1, full, memExp;
        int nRet;
        e0 = '0;
        e1 = '0;
        #18;
        v0 = model.size() > 0;
        v1 = model.size() > 1;
        if (v0) e0 = model[0];
        if (v1) e1 = model[1];
        en     = !stall && !flush && !trapHold;
        intr   = en && extInterrupt && v0;
        ready0 = en && v0 && e0.done;
        fault  = ready0 && !extInterrupt && e0.trap;
        sys    = ready0 && !extInterrupt && !e0.trap && (e0.op == opSyscall);
        trap   = intr || fault || sys;
        ret0   = ready0 && !trap;
        ret1   = ret0 && v1 && e1.done && !e1.trap && (e1.op != opSyscall) &&
                 !(isMem(e0.op) && isMem(e1.op));
        full   = model.size() > `ROB_DEPTH - 2;
        memExp = (ret0 && isMem(e0.op)) || (ret1 && isMem(e1.op));
        memE   = (ret0 && isMem(e0.op)) ? e0 : e1;
        compareValue("allocIdx0", allocIdx0, robIdxT'(headPtr + model.size()));
        compareValue("allocIdx1", allocIdx1, robIdxT'(headPtr + model.size() + 1));
        compareValue("robFull", robFull, full);
        compareValue("commitMap0", commitMap0, ret0 && e0.rdValid);
        compareValue("commitMap1", commitMap1, ret1 && e1.rdValid);
        if (ret0 && e0.rdValid) begin
            compareValue("commitArchRd0", commitArchRd0, e0.archRd);
            compareValue("commitPhysRd0", commitPhysRd0, e0.physRd);
            commitsSeen++;
        end
        if (ret1 && e1.rdValid) begin
            compareValue("commitArchRd1", commitArchRd1, e1.archRd);
            compareValue("commitPhysRd1", commitPhysRd1, e1.physRd);
            commitsSeen++;
        end
        compareValue("memRetire", memRetire, memExp);
        if (memExp) begin
            compareValue("memRetireStore", memRetireStore, memE.op == opStore);
            compareValue("memRetireBufIdx", memRetireBufIdx, memE.bufIdx);
            memSeen++;
        end
        compareValue("trapValid", trapValid, trap);
        if (trap) begin
            compareValue("trapPc", trapPc, e0.pc);
            compareValue("trapAddr", trapAddr, fault ? e0.faultAddr : 0);
            compareValue("trapCode", trapCode, intr ? `INTERRUPT_CODE :
                         fault ? e0.trapCode : `SYSCALL_CODE);
            trapsSeen++;
        end
        @(posedge Clk);
        if (flush) begin
            model.delete();
            headPtr  = '0;
            trapHold = 1'b0;
        end else if (!stall) begin
            if (aluDone0) markDone(aluDoneIdx0, 1'b0);
            if (aluDone1) markDone(aluDoneIdx1, 1'b0);
            if (memDone) markDone(memDoneIdx, 1'b1);
            if (trap) trapHold = 1'b1;
            nRet = int'(ret0) + int'(ret1);
            repeat (nRet) ent = model.pop_front();
            headPtr = headPtr + robIdxT'(nRet);
            if (dispatchValid0 && !full) begin
                model.push_back(modelEntry(dispatchPc0, dispatchOp0, dispatchRdValid0,
                                           dispatchArchRd0, dispatchPhysRd0));
                if (dispatchValid1) begin
                    model.push_back(modelEntry(dispatchPc1, dispatchOp1, dispatchRdValid1,
                                               dispatchArchRd1, dispatchPhysRd1));
                end
            end
        end
        #2;
        dispatchValid0 = 1'b0;
        dispatchValid1 = 1'b0;
        aluDone0 = 1'b0;
        aluDone1 = 1'b0;
        memDone  = 1'b0;
        memTrap  = 1'b0;
        flush    = 1'b0;
    endtask

    task automatic waitDrain(input int maxCycles);
        int n;
        n = 0;
        while (model.size() > 0 && n < maxCycles) begin
            runCycle();
            n++;
        end
        if (model.size() > 0) begin
            $display("ROB still holds %0d entries after %0d cycles", model.size(), maxCycles);
            errors++;
        end
    endtask

    task automatic memComplete(input robIdxT idx);
        memDone    = 1'b1;
        memDoneIdx = idx;
        memBufIdx  = bufIdxT'($urandom());
    endtask

    task automatic reportTest(input string name, input int startErrors);
        if (errors == startErrors) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errors - startErrors);
        end
    endtask

    task automatic testAllocOrder();
        int start, c;
        start = errors;
        c = commitsSeen;
        for (int i = 0; i < 4; i++) begin
            compareValue("allocIdx0 after reset", allocIdx0, i);
            driveSlot(0, opAlu, 1'b1);
            runCycle();
        end
        for (int i = 0; i < 4; i++) begin
            pcReadIdx = robIdxT'(i);
            #1;
            compareValue("pcReadData", pcReadData, model[i].pc);
        end
        // completion in reverse program order
        for (int i = 3; i >= 0; i--) begin
            aluDone0    = 1'b1;
            aluDoneIdx0 = robIdxT'(i);
            runCycle();
        end
        waitDrain(20);
        compareValue("commits in allocation test", commitsSeen - c, 4);
        reportTest("allocation and ALU commit order", start);
    endtask

    task automatic testMemRetire();
        int start, m;
        robIdxT base;
        start = errors;
        m = memSeen;
        base = headPtr;
        driveSlot(0, opLoad, 1'b1);
        driveSlot(1, opLoad, 1'b1);
        runCycle();
        driveSlot(0, opAlu, 1'b1);
        driveSlot(1, opStore, 1'b0);
        runCycle();
        memComplete(base + 1);
        runCycle();
        memComplete(base + 3);
        aluDone0    = 1'b1;
        aluDoneIdx0 = base + 2;
        runCycle();
        // load at the head releases the whole group
        memComplete(base);
        runCycle();
        waitDrain(20);
        compareValue("memory retires", memSeen - m, 3);
        reportTest("memory retire", start);
    endtask

    task automatic testMemTrap();
        int start, t, c;
        robIdxT base;
        start = errors;
        t = trapsSeen;
        c = commitsSeen;
        base = headPtr;
        driveSlot(0, opLoad, 1'b1);
        driveSlot(1, opAlu, 1'b1);
        runCycle();
        aluDone0     = 1'b1;
        aluDoneIdx0  = base + 1;
        memComplete(base);
        memTrap      = 1'b1;
        memTrapCode  = trapCodeT'($urandom());
        memFaultAddr = $urandom();
        runCycle();
        repeat (5) runCycle();
        compareValue("traps in fault test", trapsSeen - t, 1);
        compareValue("commits in fault test", commitsSeen - c, 0);
        flush = 1'b1;
        runCycle();
        compareValue("allocIdx0 after flush", allocIdx0, 0);
        reportTest("memory fault and flush", start);
    endtask

    task automatic testSyscall();
        int start, t, c;
        start = errors;
        t = trapsSeen;
        c = commitsSeen;
        driveSlot(0, opSyscall, 1'b1);
        runCycle();
        aluDone0    = 1'b1;
        aluDoneIdx0 = headPtr;
        runCycle();
        repeat (3) runCycle();
        compareValue("traps in syscall test", trapsSeen - t, 1);
        compareValue("commits in syscall test", commitsSeen - c, 0);
        flush = 1'b1;
        runCycle();
        reportTest("syscall", start);
    endtask

    task automatic testInterrupt();
        int start, t, c;
        start = errors;
        t = trapsSeen;
        c = commitsSeen;
        driveSlot(0, opAlu, 1'b1);
        runCycle();
        aluDone0    = 1'b1;
        aluDoneIdx0 = headPtr;
        runCycle();
        // head is done and ready to retire in this cycle
        extInterrupt = 1'b1;
        runCycle();
        extInterrupt = 1'b0;
        repeat (2) runCycle();
        compareValue("traps in interrupt test", trapsSeen - t, 1);
        compareValue("commits in interrupt test", commitsSeen - c, 0);
        flush = 1'b1;
        runCycle();
        reportTest("external interrupt", start);
    endtask

    task automatic testStallFull();
        int start, c;
        robIdxT base;
        start = errors;
        c = commitsSeen;
        base = headPtr;
        repeat (7) begin
            driveSlot(0, opAlu, 1'b1);
            driveSlot(1, opAlu, 1'b1);
            runCycle();
        end
        driveSlot(0, opAlu, 1'b1);
        runCycle();
        compareValue("robFull with 15 entries", robFull, 1);
        // refused while full
        driveSlot(0, opAlu, 1'b1);
        runCycle();
        aluDone0    = 1'b1;
        aluDoneIdx0 = base;
        aluDone1    = 1'b1;
        aluDoneIdx1 = base + 1;
        runCycle();
        // done entries wait at the head while these strobes are lost
        stall       = 1'b1;
        aluDone0    = 1'b1;
        aluDoneIdx0 = base + 2;
        aluDone1    = 1'b1;
        aluDoneIdx1 = base + 3;
        runCycle();
        runCycle();
        compareValue("commits while stalled", commitsSeen - c, 0);
        stall = 1'b0;
        repeat (2) runCycle();
        for (int i = 1; i < 8; i++) begin
            aluDone0    = 1'b1;
            aluDoneIdx0 = base + robIdxT'(2 * i);
            aluDone1    = (2 * i + 1) < 15;
            aluDoneIdx1 = base + robIdxT'(2 * i + 1);
            runCycle();
        end
        waitDrain(30);
        compareValue("commits after stall", commitsSeen - c, 15);
        compareValue("robFull after drain", robFull, 0);
        reportTest("full and stall", start);
    endtask

    initial begin
        seed = $urandom(32'hd446478e);
        {arstN, stall, flush, extInterrupt} = 4'b0000;
        {dispatchValid0, dispatchValid1, dispatchRdValid0, dispatchRdValid1} = 4'b0000;
        {dispatchPc0, dispatchPc1, memFaultAddr} = '0;
        dispatchOp0 = opAlu;
        dispatchOp1 = opAlu;
        {dispatchArchRd0, dispatchArchRd1, dispatchPhysRd0, dispatchPhysRd1} = '0;
        {aluDone0, aluDone1, memDone, memTrap} = 4'b0000;
        {aluDoneIdx0, aluDoneIdx1, memDoneIdx, pcReadIdx} = '0;
        memTrapCode = '0;
        memBufIdx = '0;
        headPtr = '0;
        trapHold = 1'b0;
        repeat (10) @(posedge Clk);
        #2;
        arstN = 1'b1;
        testAllocOrder();
        testMemRetire();
        testMemTrap();
        testSyscall();
        testInterrupt();
        testStallFull();
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- design/robTop.sv
`timescale 1ns/1ps

module robTop (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   extInterrupt,
    input  logic                   dispatchValid0,
    input  robEntryPkg::pcT        dispatchPc0,
    input  robEntryPkg::microOpE   dispatchOp0,
    input  logic                   dispatchRdValid0,
    input  robEntryPkg::archRegT   dispatchArchRd0,
    input  robEntryPkg::physRegT   dispatchPhysRd0,
    input  logic                   dispatchValid1,
    input  robEntryPkg::pcT        dispatchPc1,
    input  robEntryPkg::microOpE   dispatchOp1,
    input  logic                   dispatchRdValid1,
    input  robEntryPkg::archRegT   dispatchArchRd1,
    input  robEntryPkg::physRegT   dispatchPhysRd1,
    output robEntryPkg::robIdxT    allocIdx0,
    output robEntryPkg::robIdxT    allocIdx1,
    output logic                   robFull,
    input  logic                   aluDone0,
    input  logic                   aluDone1,
    input  robEntryPkg::robIdxT    aluDoneIdx0,
    input  robEntryPkg::robIdxT    aluDoneIdx1,
    input  logic                   memDone,
    input  robEntryPkg::robIdxT    memDoneIdx,
    input  logic                   memTrap,
    input  robEntryPkg::trapCodeT  memTrapCode,
    input  robEntryPkg::pcT        memFaultAddr,
    input  robEntryPkg::bufIdxT    memBufIdx,
    input  robEntryPkg::robIdxT    pcReadIdx,
    output robEntryPkg::pcT        pcReadData,
    output logic                   commitMap0,
    output logic                   commitMap1,
    output robEntryPkg::archRegT   commitArchRd0,
    output robEntryPkg::archRegT   commitArchRd1,
    output robEntryPkg::physRegT   commitPhysRd0,
    output robEntryPkg::physRegT   commitPhysRd1,
    output logic                   memRetire,
    output logic                   memRetireStore,
    output robEntryPkg::bufIdxT    memRetireBufIdx,
    output logic                   trapValid,
    output robEntryPkg::pcT        trapPc,
    output robEntryPkg::pcT        trapAddr,
    output robEntryPkg::trapCodeT  trapCode
);
    import robEntryPkg::*;
    import robCtrlPkg::*;

    robIdxT      headIdx;
    robIdxT      tailIdx;
    logic        retireEnable;
    logic        allocWrite0;
    logic        allocWrite1;
    robEntryT    head0Entry;
    robEntryT    head1Entry;
    retireCountT retireCount;
    logic        trapTaken;

    // slots handed back to rename
    assign allocIdx0 = tailIdx;
    assign allocIdx1 = tailIdx + 1'b1;

    robControl u_control (.*);

    robEntryStore u_store (.*);

    robRetireSelect u_retire (.*);

endmodule

//--- design/robRetireSelect.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module robRetireSelect (
    input  robEntryPkg::robEntryT   head0Entry,
    input  robEntryPkg::robEntryT   head1Entry,
    input  logic                    retireEnable,
    input  logic                    extInterrupt,
    output robCtrlPkg::retireCountT retireCount,
    output logic                    trapTaken,
    output logic                    commitMap0,
    output logic                    commitMap1,
    output robEntryPkg::archRegT    commitArchRd0,
    output robEntryPkg::archRegT    commitArchRd1,
    output robEntryPkg::physRegT    commitPhysRd0,
    output robEntryPkg::physRegT    commitPhysRd1,
    output logic                    memRetire,
    output logic                    memRetireStore,
    output robEntryPkg::bufIdxT     memRetireBufIdx,
    output logic                    trapValid,
    output robEntryPkg::pcT         trapPc,
    output robEntryPkg::pcT         trapAddr,
    output robEntryPkg::trapCodeT   trapCode
);
    import robEntryPkg::*;
    import robCtrlPkg::*;

    logic head0Ready;
    logic head1Ready;
    logic head0Mem;
    logic head1Mem;
    logic interruptTake;
    logic faultTake;
    logic syscallTake;
    logic retire0;
    logic retire1;
    logic memRetire0;
    logic memRetire1;

    assign head0Ready = retireEnable && head0Entry.valid && head0Entry.done;
    assign head1Ready = head1Entry.valid && head1Entry.done;
    assign head0Mem   = (head0Entry.op == opLoad) || (head0Entry.op == opStore);
    assign head1Mem   = (head1Entry.op == opLoad) || (head1Entry.op == opStore);

    // interrupt wins over anything at the head, done or not
    assign interruptTake = retireEnable && extInterrupt && head0Entry.valid;
    assign faultTake     = head0Ready && !extInterrupt && head0Entry.trap;
    assign syscallTake   = head0Ready && !extInterrupt && !head0Entry.trap &&
                           (head0Entry.op == opSyscall);
    assign trapTaken     = interruptTake || faultTake || syscallTake;

    assign retire0 = head0Ready && !trapTaken;
    // second slot only if it cannot trap, one memory op per cycle
    assign retire1 = retire0 && head1Ready && !head1Entry.trap &&
                     (head1Entry.op != opSyscall) && !(head0Mem && head1Mem);

    assign retireCount = retire1 ? retireCountT'(2) : retireCountT'({1'b0, retire0});

    // architectural map updates
    assign commitMap0    = retire0 && head0Entry.rdValid;
    assign commitMap1    = retire1 && head1Entry.rdValid;
    assign commitArchRd0 = commitMap0 ? head0Entry.archRd : '0;
    assign commitArchRd1 = commitMap1 ? head1Entry.archRd : '0;
    assign commitPhysRd0 = commitMap0 ? head0Entry.physRd : '0;
    assign commitPhysRd1 = commitMap1 ? head1Entry.physRd : '0;

    // load/store buffer release
    assign memRetire0      = retire0 && head0Mem;
    assign memRetire1      = retire1 && head1Mem;
    assign memRetire       = memRetire0 || memRetire1;
    assign memRetireStore  = memRetire0 ? (head0Entry.op == opStore) :
                             memRetire1 ? (head1Entry.op == opStore) : 1'b0;
    assign memRetireBufIdx = memRetire0 ? head0Entry.bufIdx :
                             memRetire1 ? head1Entry.bufIdx : '0;

    // exception report, always for the head entry
    assign trapValid = trapTaken;
    assign trapPc    = trapTaken ? head0Entry.pc : '0;
    assign trapAddr  = faultTake ? head0Entry.faultAddr : '0;
    assign trapCode  = interruptTake ? trapCodeT'(`INTERRUPT_CODE) :
                       faultTake     ? head0Entry.trapCode :
                       syscallTake   ? trapCodeT'(`SYSCALL_CODE) : '0;

    always_comb begin
        trapBlocksRetire: assert final (!(trapValid && retireCount != '0))
        else $error("trap reported in a retiring cycle");
    end

endmodule

//--- design/robEntryStore.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module robEntryStore (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   stall,
    input  logic                   flush,
    input  robEntryPkg::robIdxT    headIdx,
    input  robEntryPkg::robIdxT    tailIdx,
    input  logic                   allocWrite0,
    input  logic                   allocWrite1,
    input  robEntryPkg::pcT        dispatchPc0,
    input  robEntryPkg::microOpE   dispatchOp0,
    input  logic                   dispatchRdValid0,
    input  robEntryPkg::archRegT   dispatchArchRd0,
    input  robEntryPkg::physRegT   dispatchPhysRd0,
    input  robEntryPkg::pcT        dispatchPc1,
    input  robEntryPkg::microOpE   dispatchOp1,
    input  logic                   dispatchRdValid1,
    input  robEntryPkg::archRegT   dispatchArchRd1,
    input  robEntryPkg::physRegT   dispatchPhysRd1,
    input  logic                   aluDone0,
    input  logic                   aluDone1,
    input  robEntryPkg::robIdxT    aluDoneIdx0,
    input  robEntryPkg::robIdxT    aluDoneIdx1,
    input  logic                   memDone,
    input  robEntryPkg::robIdxT    memDoneIdx,
    input  logic                   memTrap,
    input  robEntryPkg::trapCodeT  memTrapCode,
    input  robEntryPkg::pcT        memFaultAddr,
    input  robEntryPkg::bufIdxT    memBufIdx,
    input  robEntryPkg::robIdxT    pcReadIdx,
    output robEntryPkg::pcT        pcReadData,
    output robEntryPkg::robEntryT  head0Entry,
    output robEntryPkg::robEntryT  head1Entry
);
    import robEntryPkg::*;

    robEntryT              entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] entryValid;
    logic [`ROB_DEPTH-1:0] entryDone;
    robIdxT                tailNext;
    robIdxT                headNext;
    robIdxT                prevHead;
    robIdxT                prevHeadNext;
    logic                  compWrite;

    function automatic robEntryT newEntry(pcT pc, microOpE op, logic rdValid,
                                          archRegT archRd, physRegT physRd);
        robEntryT e;
        e           = '0;
        e.valid     = 1'b1;
        e.op        = op;
        e.rdValid   = rdValid;
        e.archRd    = archRd;
        e.physRd    = physRd;
        e.pc        = pc;
        return e;
    endfunction

    assign tailNext     = tailIdx + 1'b1;
    assign headNext     = headIdx + 1'b1;
    assign prevHeadNext = prevHead + 1'b1;

    // completions are dropped while frozen or flushing
    assign compWrite = !stall && !flush;

    always_ff @(posedge Clk) begin
        if (allocWrite0) begin
            entries[tailIdx] <= newEntry(dispatchPc0, dispatchOp0, dispatchRdValid0,
                                         dispatchArchRd0, dispatchPhysRd0);
        end
        if (allocWrite1) begin
            entries[tailNext] <= newEntry(dispatchPc1, dispatchOp1, dispatchRdValid1,
                                          dispatchArchRd1, dispatchPhysRd1);
        end
        if (compWrite && memDone) begin
            entries[memDoneIdx].trap      <= memTrap;
            entries[memDoneIdx].trapCode  <= memTrapCode;
            entries[memDoneIdx].faultAddr <= memFaultAddr;
            entries[memDoneIdx].bufIdx    <= memBufIdx;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
            entryDone  <= '0;
            prevHead   <= '0;
        end else if (flush) begin
            entryValid <= '0;
            entryDone  <= '0;
            prevHead   <= '0;
        end else begin
            prevHead <= headIdx;
            // free retired slots one cycle behind the head
            if (headIdx != prevHead) begin
                entryValid[prevHead] <= 1'b0;
            end
            if (headIdx == prevHead + robIdxT'(2)) begin
                entryValid[prevHeadNext] <= 1'b0;
            end
            // allocation after the free, a slot can be reused at once
            if (allocWrite0) begin
                entryValid[tailIdx] <= 1'b1;
                entryDone[tailIdx]  <= 1'b0;
            end
            if (allocWrite1) begin
                entryValid[tailNext] <= 1'b1;
                entryDone[tailNext]  <= 1'b0;
            end
            if (compWrite && aluDone0) begin
                entryDone[aluDoneIdx0] <= 1'b1;
            end
            if (compWrite && aluDone1) begin
                entryDone[aluDoneIdx1] <= 1'b1;
            end
            if (compWrite && memDone) begin
                entryDone[memDoneIdx] <= 1'b1;
            end
        end
    end

    assign pcReadData = entries[pcReadIdx].pc;

    always_comb begin
        head0Entry       = entries[headIdx];
        head0Entry.valid = entryValid[headIdx];
        head0Entry.done  = entryDone[headIdx];
        head1Entry       = entries[headNext];
        head1Entry.valid = entryValid[headNext];
        head1Entry.done  = entryDone[headNext];
    end

    // units only complete what rename handed out
    completionTarget: assert property (
        @(posedge Clk) disable iff (!arstN || flush)
        (!aluDone0 || entryValid[aluDoneIdx0]) &&
        (!aluDone1 || entryValid[aluDoneIdx1]) &&
        (!memDone || entryValid[memDoneIdx])
    ) else $error("completion names an empty entry");

endmodule

//--- design/robControl.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module robControl (
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    dispatchValid0,
    input  logic                    dispatchValid1,
    input  robCtrlPkg::retireCountT retireCount,
    input  logic                    trapTaken,
    output robEntryPkg::robIdxT     headIdx,
    output robEntryPkg::robIdxT     tailIdx,
    output logic                    retireEnable,
    output logic                    robFull,
    output logic                    allocWrite0,
    output logic                    allocWrite1
);
    import robEntryPkg::*;
    import robCtrlPkg::*;

    retireStateE retireState;
    occupancyT   occupancy;
    retireCountT allocCount;

    // full once fewer than two slots are free
    assign robFull = occupancy > occupancyT'(`ROB_DEPTH - 2);

    assign allocWrite0 = dispatchValid0 && !robFull && !stall && !flush;
    assign allocWrite1 = allocWrite0 && dispatchValid1;
    assign allocCount  = allocWrite1 ? retireCountT'(2) : retireCountT'({1'b0, allocWrite0});

    // no retirement while frozen, flushing or parked after a trap
    assign retireEnable = !stall && !flush && (retireState == stateRun);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            headIdx     <= '0;
            tailIdx     <= '0;
            occupancy   <= '0;
            retireState <= stateRun;
        end else if (flush) begin
            headIdx     <= '0;
            tailIdx     <= '0;
            occupancy   <= '0;
            retireState <= stateRun;
        end else if (!stall) begin
            headIdx   <= headIdx + robIdxT'(retireCount);
            tailIdx   <= tailIdx + robIdxT'(allocCount);
            occupancy <= occupancy + occupancyT'(allocCount) - occupancyT'(retireCount);
            if (trapTaken) begin
                retireState <= stateTrapHold;
            end
        end
    end

    occupancyBound: assert property (
        @(posedge Clk) disable iff (!arstN)
        occupancy <= occupancyT'(`ROB_DEPTH)
    ) else $error("occupancy above buffer depth");

    // rename fills slot 0 first
    dispatchSlotOrder: assert property (
        @(posedge Clk) disable iff (!arstN)
        dispatchValid1 |-> dispatchValid0
    ) else $error("dispatch slot 1 valid without slot 0");

endmodule

//--- design/robCtrlPkg.sv
`include "rob_cfg.svh"

package robCtrlPkg;

    // retirement runs until a trap, then waits for flush
    typedef enum logic {
        stateRun      = 1'b0,
        stateTrapHold = 1'b1
    } retireStateE;

    // 0 to 2 entries per cycle
    typedef logic [1:0] retireCountT;

    // 0 to ROB_DEPTH, one bit wider than an index
    typedef logic [`ROB_IDX_W:0] occupancyT;

endpackage

//--- design/robEntryPkg.sv
`include "rob_cfg.svh"

package robEntryPkg;

    typedef logic [`ROB_IDX_W-1:0]   robIdxT;
    typedef logic [`PC_W-1:0]        pcT;
    typedef logic [`ARCH_REG_W-1:0]  archRegT;
    typedef logic [`PHYS_REG_W-1:0]  physRegT;
    typedef logic [`TRAP_CODE_W-1:0] trapCodeT;
    typedef logic [`BUF_IDX_W-1:0]   bufIdxT;

    // instruction class, only what retirement needs to know
    typedef enum logic [1:0] {
        opAlu     = 2'b00,
        opLoad    = 2'b01,
        opStore   = 2'b10,
        opSyscall = 2'b11
    } microOpE;

    typedef struct packed {
        logic     valid;
        logic     done;
        microOpE  op;
        logic     rdValid;
        archRegT  archRd;
        physRegT  physRd;
        pcT       pc;
        logic     trap;
        trapCodeT trapCode;
        // virtual address of a faulting access
        pcT       faultAddr;
        bufIdxT   bufIdx;
    } robEntryT;

endpackage

//--- include/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// buffer geometry
`define ROB_DEPTH       16
`define ROB_IDX_W       4

// datapath widths
`define PC_W            32
`define ARCH_REG_W      5
`define PHYS_REG_W      6
`define TRAP_CODE_W     7

// index into the load/store buffer
`define BUF_IDX_W       3

// exception codes the ROB raises itself
`define SYSCALL_CODE    10
`define INTERRUPT_CODE  0

`endif
